//--- src/icache_ctrl_config.svh
// Build-time configuration of the icache control unit, included by the package and RTL that decode words
`ifndef ICACHE_CTRL_CONFIG_SVH
`define ICACHE_CTRL_CONFIG_SVH

// Number of cores served by the unit
`define ICACHE_NB_CORES      4

// Peripheral bus widths
`define ICACHE_DATA_WIDTH    32
`define ICACHE_ADDR_WIDTH    32
`define ICACHE_ID_WIDTH      5

// Register word indices, taken from address bits 7:2
`define ICACHE_REG_ENABLE    6'd0
`define ICACHE_REG_FLUSH     6'd1
`define ICACHE_REG_RESERVED  6'd2

// Read patterns for words that hold no register
`define ICACHE_RD_RESERVED   32'hBADD_A555
`define ICACHE_RD_UNMAPPED   32'hDEAD_A555

`endif

//--- src/icache_ctrl_pkg.sv
// Shared types of the icache control unit, imported by its RTL and testbench
`default_nettype none

`include "icache_ctrl_config.svh"

package icache_ctrl_pkg;

    // Bus payload types
    typedef logic [`ICACHE_DATA_WIDTH-1:0] word_t;
    typedef logic [`ICACHE_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`ICACHE_ID_WIDTH-1:0]   periph_id_t;

    // One bit per core
    typedef logic [`ICACHE_NB_CORES-1:0]   core_mask_t;

    // Word index, address bits 7:2
    typedef logic [5:0]                    reg_idx_t;

    // Control FSM states
    typedef enum logic [1:0]
    {
        IDLE,           // Granting new transfers
        WAIT_ENABLE,    // Cores leaving bypass
        WAIT_DISABLE,   // Cores entering bypass
        WAIT_FLUSH      // Cores flushing
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- src/ack_collector.sv
// Sticky per-core acknowledge tracker; raises all_acked once each core showed the wanted level
`timescale 1ns/1ps
`default_nettype none

module ack_collector
#(
    parameter bit ACK_LEVEL = 1'b1      // Level that counts as an acknowledge
)
(
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        listen_i,
    input  logic                        clear_i,
    input  icache_ctrl_pkg::core_mask_t ack_i,
    output logic                        all_acked_o
);
    import icache_ctrl_pkg::*;

    core_mask_t acked_q;
    core_mask_t ack_match;

    // Cores currently showing the wanted level
    assign ack_match = ACK_LEVEL ? ack_i : ~ack_i;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
            acked_q <= '0;
        else if (clear_i)
            acked_q <= '0;      // Clear wins over a listen in the same cycle
        else if (listen_i)
            acked_q <= acked_q | ack_match;
    end

    assign all_acked_o = &acked_q;

endmodule

`default_nettype wire

//--- src/icache_ctrl_fsm.sv
// Control FSM of the icache control unit; grants transfers, decodes writes and waits for core acks
`timescale 1ns/1ps
`default_nettype none

`include "icache_ctrl_config.svh"

module icache_ctrl_fsm
(
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      req_i,
    input  logic                      wen_i,      // High means read
    input  icache_ctrl_pkg::addr_t    addr_i,
    input  icache_ctrl_pkg::word_t    wdata_i,
    input  logic                      enable_acked_i,
    input  logic                      disable_acked_i,
    input  logic                      flush_acked_i,
    output logic                      gnt_o,
    output logic                      rd_strobe_o,
    output icache_ctrl_pkg::reg_idx_t rd_idx_o,
    output logic                      wr_enable_o,
    output logic                      wr_flush_o,
    output logic                      deliver_write_o,
    output logic                      listen_enable_o,
    output logic                      listen_disable_o,
    output logic                      listen_flush_o,
    output logic                      clear_enable_o,
    output logic                      clear_disable_o,
    output logic                      clear_flush_o
);
    import icache_ctrl_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    reg_idx_t    word_idx;
    logic        xfer;

    assign word_idx = addr_i[7:2];
    assign rd_idx_o = word_idx;
    assign gnt_o    = (state_q == IDLE);    // No grant while waiting on cores
    assign xfer     = gnt_o & req_i;

    always_comb
    begin
        state_d          = state_q;
        rd_strobe_o      = 1'b0;
        wr_enable_o      = 1'b0;
        wr_flush_o       = 1'b0;
        deliver_write_o  = 1'b0;
        listen_enable_o  = 1'b0;
        listen_disable_o = 1'b0;
        listen_flush_o   = 1'b0;
        clear_enable_o   = 1'b0;
        clear_disable_o  = 1'b0;
        clear_flush_o    = 1'b0;

        case (state_q)
            IDLE:
            begin
                if (xfer && wen_i)
                    rd_strobe_o = 1'b1;
                else if (xfer)
                begin
                    case (word_idx)
                        `ICACHE_REG_ENABLE:
                        begin
                            wr_enable_o = 1'b1;
                            // Zero word means every core goes to bypass
                            state_d     = (wdata_i == '0) ? WAIT_DISABLE : WAIT_ENABLE;
                        end
                        `ICACHE_REG_FLUSH:
                        begin
                            wr_flush_o = 1'b1;
                            state_d    = WAIT_FLUSH;
                        end
                        default: deliver_write_o = 1'b1;  // Ack with no effect
                    endcase
                end
            end

            WAIT_ENABLE:
            begin
                listen_enable_o = 1'b1;
                if (enable_acked_i)
                begin
                    clear_enable_o  = 1'b1;
                    deliver_write_o = 1'b1;
                    state_d         = IDLE;
                end
            end

            WAIT_DISABLE:
            begin
                listen_disable_o = 1'b1;
                if (disable_acked_i)
                begin
                    clear_disable_o = 1'b1;
                    deliver_write_o = 1'b1;
                    state_d         = IDLE;
                end
            end

            WAIT_FLUSH:
            begin
                listen_flush_o = 1'b1;
                if (flush_acked_i)
                begin
                    clear_flush_o   = 1'b1;
                    deliver_write_o = 1'b1;
                    state_d         = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

endmodule

`default_nettype wire

//--- src/icache_ctrl_regs.sv
// Enable and flush registers of the icache control unit, with read mux and per-core request outputs
`timescale 1ns/1ps
`default_nettype none

`include "icache_ctrl_config.svh"

module icache_ctrl_regs
(
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        wr_enable_i,
    input  logic                        wr_flush_i,
    input  icache_ctrl_pkg::word_t      wdata_i,
    input  icache_ctrl_pkg::reg_idx_t   rd_idx_i,
    output icache_ctrl_pkg::word_t      rd_data_o,
    output icache_ctrl_pkg::core_mask_t bypass_req_o,
    output icache_ctrl_pkg::core_mask_t flush_req_o
);
    import icache_ctrl_pkg::*;

    word_t enable_q;
    word_t flush_q;

    // Writes land on the transfer edge
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            enable_q <= '0;
            flush_q  <= '0;
        end
        else
        begin
            if (wr_enable_i)
                enable_q <= wdata_i;
            if (wr_flush_i)
                flush_q  <= wdata_i;
        end
    end

    always_comb
    begin
        case (rd_idx_i)
            `ICACHE_REG_ENABLE:   rd_data_o = enable_q;
            `ICACHE_REG_FLUSH:    rd_data_o = flush_q;
            `ICACHE_REG_RESERVED: rd_data_o = `ICACHE_RD_RESERVED;
            default:              rd_data_o = `ICACHE_RD_UNMAPPED;
        endcase
    end

    // A cleared enable bit puts that core in bypass
    assign bypass_req_o = ~enable_q[`ICACHE_NB_CORES-1:0];
    assign flush_req_o  = flush_q[`ICACHE_NB_CORES-1:0];

endmodule

`default_nettype wire

//--- src/periph_resp_port.sv
// Registered peripheral bus response path; one response per transfer with the captured id
`timescale 1ns/1ps
`default_nettype none

module periph_resp_port
(
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        req_i,
    input  logic                        gnt_i,
    input  icache_ctrl_pkg::periph_id_t id_i,
    input  logic                        rd_strobe_i,
    input  icache_ctrl_pkg::word_t      rd_data_i,
    input  logic                        deliver_write_i,
    output logic                        r_valid_o,
    output logic                        r_opc_o,
    output icache_ctrl_pkg::periph_id_t r_id_o,
    output icache_ctrl_pkg::word_t      r_rdata_o
);

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            r_valid_o <= 1'b0;
            r_rdata_o <= '0;
            r_id_o    <= '0;
        end
        else
        begin
            // Held through a wait state, since no grant is given there
            if (req_i && gnt_i)
                r_id_o <= id_i;

            r_valid_o <= rd_strobe_i | deliver_write_i;

            if (rd_strobe_i)
                r_rdata_o <= rd_data_i;
            else
                r_rdata_o <= '0;    // Write responses and idle cycles
        end
    end

    assign r_opc_o = 1'b0;  // No error responses

endmodule

`default_nettype wire

//--- src/icache_ctrl_unit.sv
// Top level of the icache control unit, a bus slave driving bypass and flush requests to the cores
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl_unit
(
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        req_i,
    input  icache_ctrl_pkg::addr_t      addr_i,
    input  logic                        wen_i,
    input  icache_ctrl_pkg::word_t      wdata_i,
    input  icache_ctrl_pkg::periph_id_t id_i,
    input  icache_ctrl_pkg::core_mask_t bypass_ack_i,
    input  icache_ctrl_pkg::core_mask_t flush_ack_i,
    output logic                        gnt_o,
    output logic                        r_valid_o,
    output logic                        r_opc_o,
    output icache_ctrl_pkg::periph_id_t r_id_o,
    output icache_ctrl_pkg::word_t      r_rdata_o,
    output icache_ctrl_pkg::core_mask_t bypass_req_o,
    output icache_ctrl_pkg::core_mask_t flush_req_o
);
    import icache_ctrl_pkg::*;

    logic     rd_strobe;
    reg_idx_t rd_idx;
    word_t    rd_data;
    logic     wr_enable;
    logic     wr_flush;
    logic     deliver_write;
    logic     listen_enable;
    logic     listen_disable;
    logic     listen_flush;
    logic     clear_enable;
    logic     clear_disable;
    logic     clear_flush;
    logic     enable_acked;
    logic     disable_acked;
    logic     flush_acked;

    icache_ctrl_fsm u_fsm
    (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_i            (req_i),
        .wen_i            (wen_i),
        .addr_i           (addr_i),
        .wdata_i          (wdata_i),
        .enable_acked_i   (enable_acked),
        .disable_acked_i  (disable_acked),
        .flush_acked_i    (flush_acked),
        .gnt_o            (gnt_o),
        .rd_strobe_o      (rd_strobe),
        .rd_idx_o         (rd_idx),
        .wr_enable_o      (wr_enable),
        .wr_flush_o       (wr_flush),
        .deliver_write_o  (deliver_write),
        .listen_enable_o  (listen_enable),
        .listen_disable_o (listen_disable),
        .listen_flush_o   (listen_flush),
        .clear_enable_o   (clear_enable),
        .clear_disable_o  (clear_disable),
        .clear_flush_o    (clear_flush)
    );

    icache_ctrl_regs u_regs
    (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .wr_enable_i  (wr_enable),
        .wr_flush_i   (wr_flush),
        .wdata_i      (wdata_i),
        .rd_idx_i     (rd_idx),
        .rd_data_o    (rd_data),
        .bypass_req_o (bypass_req_o),
        .flush_req_o  (flush_req_o)
    );

    // Enable completes when every core has left bypass
    ack_collector #(.ACK_LEVEL(1'b0)) u_ack_enable
    (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .listen_i    (listen_enable),
        .clear_i     (clear_enable),
        .ack_i       (bypass_ack_i),
        .all_acked_o (enable_acked)
    );

    ack_collector #(.ACK_LEVEL(1'b1)) u_ack_disable
    (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .listen_i    (listen_disable),
        .clear_i     (clear_disable),
        .ack_i       (bypass_ack_i),
        .all_acked_o (disable_acked)
    );

    ack_collector #(.ACK_LEVEL(1'b1)) u_ack_flush
    (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .listen_i    (listen_flush),
        .clear_i     (clear_flush),
        .ack_i       (flush_ack_i),
        .all_acked_o (flush_acked)
    );

    periph_resp_port u_resp
    (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_i           (req_i),
        .gnt_i           (gnt_o),
        .id_i            (id_i),
        .rd_strobe_i     (rd_strobe),
        .rd_data_i       (rd_data),
        .deliver_write_i (deliver_write),
        .r_valid_o       (r_valid_o),
        .r_opc_o         (r_opc_o),
        .r_id_o          (r_id_o),
        .r_rdata_o       (r_rdata_o)
    );

endmodule

`default_nettype wire

//--- sim/cache_bank_model.sv
// Behavioral model of the cores' cache banks, answering bypass and flush requests after random delays
`timescale 1ns/1ps
`default_nettype none

module cache_bank_model
(
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  icache_ctrl_pkg::core_mask_t bypass_req_i,
    input  icache_ctrl_pkg::core_mask_t flush_req_i,
    output icache_ctrl_pkg::core_mask_t bypass_ack_o,
    output icache_ctrl_pkg::core_mask_t flush_ack_o
);
    import icache_ctrl_pkg::*;

    localparam int NB_CORES = $bits(core_mask_t);

    integer     seed = 32'hc84b85a4;
    int         bypass_cnt [NB_CORES];    // Cycles left until the ack follows the request
    int         flush_cnt  [NB_CORES];
    core_mask_t flush_req_q;

    // Delay of 1 to 6 cycles
    function automatic int random_delay();
        random_delay = 1 + int'($unsigned($random(seed)) % 6);
    endfunction

    always @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            bypass_ack_o <= '1;     // Cores start in bypass
            flush_ack_o  <= '0;
            flush_req_q  <= '0;
            for (int c = 0; c < NB_CORES; c++)
            begin
                bypass_cnt[c] = 0;
                flush_cnt[c]  = 0;
            end
        end
        else
        begin
            flush_ack_o <= '0;
            flush_req_q <= flush_req_i;
            for (int c = 0; c < NB_CORES; c++)
            begin
                if (bypass_ack_o[c] != bypass_req_i[c])
                begin
                    if (bypass_cnt[c] == 0)
                        bypass_cnt[c] = random_delay();
                    else if (bypass_cnt[c] == 1)
                    begin
                        bypass_ack_o[c] <= bypass_req_i[c];
                        bypass_cnt[c] = 0;
                    end
                    else
                        bypass_cnt[c] = bypass_cnt[c] - 1;
                end

                // One flush pulse per rising request
                if (flush_req_i[c] && !flush_req_q[c])
                    flush_cnt[c] = random_delay();
                else if (flush_cnt[c] == 1)
                begin
                    flush_ack_o[c] <= 1'b1;
                    flush_cnt[c] = 0;
                end
                else if (flush_cnt[c] > 1)
                    flush_cnt[c] = flush_cnt[c] - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_icache_ctrl_unit.sv
// Directed testbench of the icache control unit; run through the file list with a simulator
`timescale 1ns/1ps
`default_nettype none

`include "icache_ctrl_config.svh"

module tb_icache_ctrl_unit;
    import icache_ctrl_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic       clk;
    logic       rst_n;
    logic       req;
    addr_t      addr;
    logic       wen;
    word_t      wdata;
    periph_id_t id;
    core_mask_t bypass_ack;
    core_mask_t flush_ack;
    logic       gnt;
    logic       r_valid;
    logic       r_opc;
    periph_id_t r_id;
    word_t      r_rdata;
    core_mask_t bypass_req;
    core_mask_t flush_req;

    int         mismatch_count;
    int         timeout_count;
    word_t      exp_enable;         // Register contents expected after each write
    word_t      exp_flush;
    word_t      resp_data;
    int         resp_cycles;        // Cycles from transfer edge to response
    core_mask_t seen_low;           // Ack levels seen while a write waits
    core_mask_t seen_high;
    core_mask_t seen_flush;

    icache_ctrl_unit u_icache_ctrl_unit
    (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .req_i        (req),
        .addr_i       (addr),
        .wen_i        (wen),
        .wdata_i      (wdata),
        .id_i         (id),
        .bypass_ack_i (bypass_ack),
        .flush_ack_i  (flush_ack),
        .gnt_o        (gnt),
        .r_valid_o    (r_valid),
        .r_opc_o      (r_opc),
        .r_id_o       (r_id),
        .r_rdata_o    (r_rdata),
        .bypass_req_o (bypass_req),
        .flush_req_o  (flush_req)
    );

    cache_bank_model u_banks
    (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .bypass_req_i (bypass_req),
        .flush_req_i  (flush_req),
        .bypass_ack_o (bypass_ack),
        .flush_ack_o  (flush_ack)
    );

    always #50 clk = ~clk;

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_mask(input string what, input core_mask_t got, input core_mask_t exp);
        if (got !== exp)
        begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_id(input string what, input periph_id_t got, input periph_id_t exp);
        if (got !== exp)
        begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_cycles(input string what, input int got, input int exp);
        if (got != exp)
        begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic addr_t word_addr(input reg_idx_t idx);
        word_addr = addr_t'(idx) << 2;
    endfunction

    // One transfer, then wait for its response while recording core acks
    task automatic bus_transfer(input logic is_read, input addr_t a, input word_t d,
                                input periph_id_t tid);
        int          waited;
        logic        granted;
        ctrl_state_e dbg_state;
        req     = 1'b1;
        wen     = is_read;
        addr    = a;
        wdata   = d;
        id      = tid;
        granted = 1'b0;
        waited  = 0;
        while (!granted && waited < TIMEOUT_CYCLES)
        begin
            granted = gnt;      // Stable between edges
            @(posedge clk);
            #1;
            waited++;
        end
        req   = 1'b0;
        wen   = 1'b1;
        addr  = '0;
        wdata = '0;
        if (!granted)
        begin
            timeout_count++;
            $display("Timeout at %0t: request with id %0d was never granted", $time, tid);
            return;
        end
        seen_low    = '0;
        seen_high   = '0;
        seen_flush  = '0;
        resp_cycles = 1;
        while (!r_valid && resp_cycles <= TIMEOUT_CYCLES)
        begin
            seen_low   |= ~bypass_ack;
            seen_high  |= bypass_ack;
            seen_flush |= flush_ack;
            check_bit("gnt_o while waiting", gnt, 1'b0);
            @(posedge clk);
            #1;
            resp_cycles++;
        end
        if (!r_valid)
        begin
            dbg_state = u_icache_ctrl_unit.u_fsm.state_q;
            timeout_count++;
            $display("Timeout at %0t: no response for id %0d, FSM in %s",
                     $time, tid, dbg_state.name());
            return;
        end
        resp_data = r_rdata;
        check_id("r_id_o", r_id, tid);
        check_bit("r_opc_o", r_opc, 1'b0);
        @(posedge clk);
        #1;
        check_bit("r_valid_o after response", r_valid, 1'b0);   // One-cycle pulse
    endtask

    task automatic bus_write(input reg_idx_t idx, input word_t d, input periph_id_t tid);
        bus_transfer(1'b0, word_addr(idx), d, tid);
        check_word("write response data", resp_data, '0);
    endtask

    task automatic bus_read(input reg_idx_t idx, input periph_id_t tid, input word_t exp);
        bus_transfer(1'b1, word_addr(idx), '0, tid);
        check_word("read data", resp_data, exp);
        check_cycles("read response", resp_cycles, 1);
    endtask

    // Wait until each core's bypass ack has followed its request
    task automatic wait_bypass_settled();
        int waited;
        waited = 0;
        while (bypass_ack !== bypass_req && waited < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (bypass_ack !== bypass_req)
        begin
            timeout_count++;
            $display("Timeout at %0t: bypass acks never followed the requests", $time);
        end
    endtask

    task automatic test_after_reset();
        check_bit("gnt_o after reset", gnt, 1'b1);
        check_bit("r_valid_o after reset", r_valid, 1'b0);
        check_mask("bypass_req_o after reset", bypass_req, '1);
        check_mask("flush_req_o after reset", flush_req, '0);
    endtask

    task automatic test_readback();
        exp_enable = 32'hCAFE_00FF;     // Every core enabled
        bus_write(`ICACHE_REG_ENABLE, exp_enable, 5'd1);
        check_mask("bypass acks seen low", seen_low, '1);
        bus_read(`ICACHE_REG_ENABLE, 5'd2, exp_enable);
        bus_read(`ICACHE_REG_FLUSH, 5'd3, exp_flush);
        bus_read(`ICACHE_REG_RESERVED, 5'd4, `ICACHE_RD_RESERVED);
        bus_read(6'd9, 5'd5, `ICACHE_RD_UNMAPPED);
    endtask

    task automatic test_enable();
        // Cores 0 and 2 go to bypass first so their acks must fall again
        bus_write(`ICACHE_REG_ENABLE, 32'h0000_000A, 5'd9);
        wait_bypass_settled();
        exp_enable = 32'h0000_0005;
        bus_write(`ICACHE_REG_ENABLE, exp_enable, 5'd6);
        check_mask("bypass_req_o", bypass_req, ~exp_enable[`ICACHE_NB_CORES-1:0]);
        check_mask("bypass acks seen low", seen_low, '1);
        bus_read(`ICACHE_REG_ENABLE, 5'd7, exp_enable);
    endtask

    task automatic test_disable();
        exp_enable = '0;
        bus_write(`ICACHE_REG_ENABLE, exp_enable, 5'd8);
        check_mask("bypass_req_o", bypass_req, '1);
        check_mask("bypass acks seen high", seen_high, '1);
    endtask

    task automatic test_flush();
        exp_flush = 32'hFFFF_FFFF;
        bus_write(`ICACHE_REG_FLUSH, exp_flush, 5'd10);
        check_mask("flush_req_o", flush_req, exp_flush[`ICACHE_NB_CORES-1:0]);
        check_mask("flush acks seen", seen_flush, '1);
        bus_read(`ICACHE_REG_FLUSH, 5'd11, exp_flush);
    endtask

    task automatic write_no_effect(input reg_idx_t idx, input periph_id_t tid);
        bus_write(idx, 32'h1234_5678, tid);
        check_cycles("write without effect", resp_cycles, 1);
        check_mask("bypass_req_o", bypass_req, ~exp_enable[`ICACHE_NB_CORES-1:0]);
        check_mask("flush_req_o", flush_req, exp_flush[`ICACHE_NB_CORES-1:0]);
    endtask

    initial
    begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        req            = 1'b0;
        wen            = 1'b1;
        addr           = '0;
        wdata          = '0;
        id             = '0;
        mismatch_count = 0;
        timeout_count  = 0;
        exp_enable     = '0;
        exp_flush      = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        test_after_reset();
        test_readback();
        test_enable();
        test_disable();
        test_flush();
        write_no_effect(`ICACHE_REG_RESERVED, 5'd12);
        write_no_effect(6'd20, 5'd13);

        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- icache_ctrl_unit.f
+incdir+src
src/icache_ctrl_pkg.sv
src/ack_collector.sv
src/icache_ctrl_fsm.sv
src/icache_ctrl_regs.sv
src/periph_resp_port.sv
src/icache_ctrl_unit.sv
sim/cache_bank_model.sv
sim/tb_icache_ctrl_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing -f icache_ctrl_unit.f --top-module tb_icache_ctrl_unit \
    -o sim_icache_ctrl_unit
./obj_dir/sim_icache_ctrl_unit | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
